/* sources.f */
hw/cpu16_pkg.sv
hw/alu.sv
hw/reg_file.sv
hw/pc_unit.sv
hw/control_fsm.sv
hw/cpu16_core.sv
verification/cpu16_core_assertions.sv
verification/tb_cpu16_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module tb_cpu16_core -o sim_cpu16 \
	|| { echo "Build failed"; exit 1; }

./obj_dir/sim_cpu16 > sim.log 2>&1 || echo "Simulator exited with an error" >> sim.log
cat sim.log

grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulator exited with an error" sim.log && { echo "FAIL"; exit 1; }
echo "PASS"

/* verification/tb_cpu16_core.sv */
module tb_cpu16_core;
	timeunit 1ns;
	timeprecision 1ps;

	import cpu16_pkg::*;

	localparam int CLK_PERIOD       = 100;
	localparam int DRIVE_DELAY      = 10;    // Inputs change after the rising edge
	localparam int RESET_CYCLES     = 10;
	localparam int INSTR_COUNT      = 54;    // Instructions over all tests
	localparam int CYCLES_PER_INSTR = 8;     // Fetch, up to four cycles of memory, execute, writeback
	localparam int WATCHDOG_CYCLES  = INSTR_COUNT * CYCLES_PER_INSTR + RESET_CYCLES + 50;

	logic    clk;
	logic    arst_n;
	logic    fetch_req;
	word_t   fetch_addr;
	logic    instr_valid;
	word_t   instr;
	logic    retire_valid;
	retire_t retire;

	word_t       imem [word_t];             // Filled by the tests as they run
	word_t       model_regs [REG_COUNT];
	logic        model_t;
	word_t       model_pc;
	int unsigned cycle;
	int unsigned valid_cycle;               // Cycle of the last instr_valid
	int          errors;
	int          checks;
	integer      seed = 32'hc048;

	cpu16_core cpu16_core_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.fetch_req    (fetch_req),
		.fetch_addr   (fetch_addr),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.retire_valid (retire_valid),
		.retire       (retire)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	initial begin
		cycle = 0;
		forever begin
			@(posedge clk);
			cycle++;
		end
	end

	////////////////////////////////////////////////////////////
	// Instruction memory, answers each fetch after 1..4 cycles
	////////////////////////////////////////////////////////////

	initial begin
		word_t addr;
		int    delay;
		forever begin
			@(negedge clk);
			if (arst_n && fetch_req) begin
				addr  = fetch_addr;
				delay = 1 + int'($unsigned($random(seed)) % 4);
				repeat (delay) @(posedge clk);
				#DRIVE_DELAY;
				instr_valid = 1'b1;
				instr       = imem.exists(addr) ? imem[addr] : {OP_NOP, 11'h000};
				valid_cycle = cycle;
				@(posedge clk);
				#DRIVE_DELAY;
				instr_valid = 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_word(input string name, input word_t got, input word_t want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("Mismatch %s: got %h, expected %h at %0t", name, got, want, $time);
		end
	endtask

	task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("Mismatch %s: got %h, expected %h at %0t", name, got, want, $time);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("Mismatch %s: got %h, expected %h at %0t", name, got, want, $time);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic void predict(input word_t ins, output retire_t want,
		output word_t next_pc);
		reg_idx_t rx;
		reg_idx_t ry;
		reg_idx_t rz;
		word_t    off8;
		word_t    src;
		int       amt;
		rx   = ins[10:8];
		ry   = ins[7:5];
		rz   = ins[4:2];
		off8 = word_t'($signed(ins[7:0]));
		src  = model_regs[ry];
		amt  = (ins[4:2] == 3'd0) ? 8 : int'(ins[4:2]);  // Zero means eight
		want         = '0;
		want.pc      = model_pc;
		want.t_value = model_t;
		next_pc      = model_pc + 16'd1;
		case (ins[15:11])
			OP_LI: begin
				want.reg_we   = 1'b1;
				want.rd       = rx;
				want.rd_value = {8'h00, ins[7:0]};
			end
			OP_ADDIU: begin
				want.reg_we   = 1'b1;
				want.rd       = rx;
				want.rd_value = model_regs[rx] + off8;
			end
			OP_ADDIU3: begin
				want.reg_we   = 1'b1;
				want.rd       = ry;
				want.rd_value = model_regs[rx] + word_t'($signed(ins[3:0]));
			end
			OP_MOVE: begin
				if (ins[4:0] == 5'b00000) begin
					want.reg_we   = 1'b1;
					want.rd       = rx;
					want.rd_value = src;
				end
			end
			OP_SHIFT: begin
				want.rd = rx;
				if (ins[1:0] == 2'b00) begin
					want.reg_we   = 1'b1;
					want.rd_value = src << amt;
				end else if (ins[1:0] == 2'b10) begin
					want.reg_we   = 1'b1;
					want.rd_value = src >> amt;
				end else if (ins[1:0] == 2'b11) begin
					want.reg_we   = 1'b1;
					want.rd_value = word_t'($signed(src) >>> amt);
				end
			end
			OP_RRR: begin
				want.rd = rz;
				if (ins[1:0] == 2'b01) begin
					want.reg_we   = 1'b1;
					want.rd_value = model_regs[rx] + src;
				end else if (ins[1:0] == 2'b11) begin
					want.reg_we   = 1'b1;
					want.rd_value = model_regs[rx] - src;
				end
			end
			OP_RR: begin
				want.rd = rx;
				if (ins[7:0] == 8'h00) begin
					next_pc = model_regs[rx];                   // JR
				end else if (ins[4:0] == 5'b01100) begin
					want.reg_we   = 1'b1;
					want.rd_value = model_regs[rx] & src;
				end else if (ins[4:0] == 5'b01101) begin
					want.reg_we   = 1'b1;
					want.rd_value = model_regs[rx] | src;
				end else if (ins[4:0] == 5'b01010) begin
					want.t_we    = 1'b1;
					want.t_value = (model_regs[rx] != src);     // CMP
				end
			end
			OP_B: begin
				next_pc = model_pc + 16'd1 + word_t'($signed(ins[10:0]));
			end
			OP_BEQZ: begin
				if (model_regs[rx] == 16'h0000) begin
					next_pc = model_pc + 16'd1 + off8;
				end
			end
			OP_BNEZ: begin
				if (model_regs[rx] != 16'h0000) begin
					next_pc = model_pc + 16'd1 + off8;
				end
			end
			OP_BTEQZ_GROUP: begin
				if (rx == 3'd0 && !model_t) begin
					next_pc = model_pc + 16'd1 + off8;
				end
			end
			default: begin
				next_pc = model_pc + 16'd1;                     // Retires as NOP
			end
		endcase
	endfunction

	// Places one instruction at the model PC, waits for its retire and checks it
	task automatic run_instr(input word_t ins);
		retire_t want;
		word_t   next_pc;
		imem[model_pc] = ins;
		predict(ins, want, next_pc);
		@(negedge clk);
		while (!retire_valid) begin
			@(negedge clk);
		end
		if (cycle - valid_cycle != 2) begin
			errors++;
			$display("Error: retire_valid came %0d cycles after instr_valid instead of 2",
				cycle - valid_cycle);
		end
		check_word("retire.pc", retire.pc, want.pc);
		check_flag("retire.reg_we", retire.reg_we, want.reg_we);
		if (want.reg_we) begin
			check_reg("retire.rd", retire.rd, want.rd);
			check_word("retire.rd_value", retire.rd_value, want.rd_value);
			model_regs[want.rd] = want.rd_value;
		end
		check_flag("retire.t_we", retire.t_we, want.t_we);
		check_flag("retire.t_value", retire.t_value, want.t_value);
		model_t  = want.t_value;
		model_pc = next_pc;
		@(negedge clk);
		if (!fetch_req) begin
			errors++;
			$display("Error: no fetch_req in the cycle after retire_valid");
		end
		check_word("fetch_addr", fetch_addr, model_pc);
	endtask

	// Builds a full 16-bit value from LI, SLL by eight and OR
	task automatic load_word16(input reg_idx_t rx, input reg_idx_t scratch, input word_t value);
		run_instr({OP_LI, rx, value[15:8]});
		run_instr({OP_SHIFT, rx, rx, 3'd0, 2'b00});
		run_instr({OP_LI, scratch, value[7:0]});
		run_instr({OP_RR, rx, scratch, 5'b01101});
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic reset_first_fetch();
		model_pc = '0;
		model_t  = 1'b0;
		for (int i = 0; i < REG_COUNT; i++) begin
			model_regs[i] = '0;
		end
		arst_n = 1'b0;
		repeat (RESET_CYCLES - 1) @(posedge clk);
		@(negedge clk);
		check_flag("fetch_req", fetch_req, 1'b0);
		check_flag("retire_valid", retire_valid, 1'b0);
		check_word("fetch_addr", fetch_addr, 16'h0000);
		@(posedge clk);
		#DRIVE_DELAY;
		arst_n = 1'b1;
		@(negedge clk);
		while (!fetch_req) begin
			if (retire_valid) begin
				errors++;
				$display("Error: retire_valid before any instruction was supplied");
			end
			@(negedge clk);
		end
		check_word("fetch_addr", fetch_addr, model_pc);
	endtask

	task automatic arith_sequence();
		run_instr({OP_LI, 3'd1, 8'hff});
		run_instr({OP_ADDIU, 3'd1, 8'h01});
		run_instr({OP_ADDIU3, 3'd1, 3'd2, 1'b0, 4'hf});   // Minus one
		run_instr({OP_LI, 3'd3, 8'h00});
		run_instr({OP_ADDIU, 3'd3, 8'h80});              // Negative immediate
		run_instr({OP_RRR, 3'd3, 3'd3, 3'd4, 2'b01});    // ADDU with carry out
		run_instr({OP_RRR, 3'd1, 3'd3, 3'd5, 2'b11});    // SUBU with borrow
		run_instr({OP_MOVE, 3'd6, 3'd5, 5'b00000});
		run_instr({OP_ADDIU, 3'd6, 8'h7f});
	endtask

	task automatic logic_shift_cmp();
		word_t      a;
		word_t      b;
		logic [2:0] amt;
		a     = word_t'($random(seed));
		b     = word_t'($random(seed));
		a[15] = 1'b0;
		b[15] = 1'b1;                                    // Negative SRA operand
		load_word16(3'd1, 3'd0, a);
		load_word16(3'd3, 3'd0, b);
		run_instr({OP_MOVE, 3'd4, 3'd1, 5'b00000});
		run_instr({OP_RR, 3'd4, 3'd3, 5'b01100});        // AND
		run_instr({OP_MOVE, 3'd5, 3'd1, 5'b00000});
		run_instr({OP_RR, 3'd5, 3'd3, 5'b01101});        // OR
		amt = 3'($random(seed));
		run_instr({OP_SHIFT, 3'd6, 3'd3, amt, 2'b00});
		run_instr({OP_SHIFT, 3'd6, 3'd3, 3'd0, 2'b11});
		amt = 3'($random(seed));
		run_instr({OP_SHIFT, 3'd7, 3'd3, amt, 2'b11});
		run_instr({OP_SHIFT, 3'd7, 3'd3, 3'd0, 2'b10});
		amt = 3'($random(seed));
		run_instr({OP_SHIFT, 3'd2, 3'd1, amt, 2'b10});
		run_instr({OP_RR, 3'd1, 3'd1, 5'b01010});        // CMP equal
		run_instr({OP_RR, 3'd1, 3'd3, 5'b01010});        // CMP unequal
	endtask

	task automatic branch_cases();
		run_instr({OP_LI, 3'd1, 8'h00});
		run_instr({OP_LI, 3'd2, 8'h05});
		run_instr({OP_BEQZ, 3'd1, 8'h03});               // Taken forward
		run_instr({OP_BEQZ, 3'd2, 8'h03});
		run_instr({OP_BNEZ, 3'd2, 8'hfe});               // Taken backward
		run_instr({OP_BNEZ, 3'd1, 8'hfe});
		run_instr({OP_B, 11'h004});
		run_instr({OP_B, 11'h7fd});                      // Minus three
		run_instr({OP_RR, 3'd1, 3'd1, 5'b01010});        // T cleared
		run_instr({OP_BTEQZ_GROUP, 3'd0, 8'h02});
		run_instr({OP_RR, 3'd1, 3'd2, 5'b01010});        // T set
		run_instr({OP_BTEQZ_GROUP, 3'd0, 8'hfd});
	endtask

	task automatic jump_and_nop();
		run_instr({OP_LI, 3'd3, 8'hc8});
		run_instr({OP_RR, 3'd3, 8'h00});                 // JR
		run_instr({OP_NOP, 11'h000});
		run_instr({5'b10011, 11'h2a5});                  // LW is not supported
		run_instr({OP_RR, 3'd1, 3'd2, 5'b00011});
		run_instr({5'b11111, 11'h7ff});
	endtask

	task automatic random_delay_timing();
		reg_idx_t   rx;
		logic [7:0] imm;
		for (int i = 0; i < 8; i++) begin
			rx  = 3'($random(seed));
			imm = 8'($random(seed));
			run_instr({OP_ADDIU, rx, imm});
		end
	endtask

	initial begin
		arst_n      = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		errors      = 0;
		checks      = 0;
		valid_cycle = 0;
		reset_first_fetch();
		arith_sequence();
		logic_shift_cmp();
		branch_cases();
		jump_and_nop();
		random_delay_timing();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the core stopped retiring instructions after %0d cycles", cycle);
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("Finished with errors");
		$finish;
	end

endmodule

/* verification/cpu16_core_assertions.sv */
module cpu16_core_assertions (
	input logic clk,
	input logic arst_n,
	input logic fetch_req,
	input logic instr_valid,
	input logic retire_valid
);
	timeunit 1ns;
	timeprecision 1ps;

	logic in_flight;    // Fetch issued, retire not yet seen
	logic answered;     // instr_valid already seen for this fetch

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			in_flight <= 1'b0;
		end else if (fetch_req) begin
			in_flight <= 1'b1;
		end else if (retire_valid) begin
			in_flight <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			answered <= 1'b0;
		end else if (fetch_req) begin
			answered <= 1'b0;
		end else if (instr_valid) begin
			answered <= 1'b1;
		end
	end

	fetch_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		fetch_req |=> !fetch_req)
		else $error("fetch_req stayed high for more than one cycle");

	retire_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		retire_valid |=> !retire_valid)
		else $error("retire_valid stayed high for more than one cycle");

	retire_after_valid: assert property (@(posedge clk) disable iff (!arst_n)
		$past(instr_valid, 2) |-> retire_valid)
		else $error("No retire two cycles after instr_valid");

	retire_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
		retire_valid |-> $past(instr_valid, 2))
		else $error("retire_valid without instr_valid two cycles before");

	single_fetch: assert property (@(posedge clk) disable iff (!arst_n)
		fetch_req |-> !in_flight)
		else $error("Second fetch_req before the previous instruction retired");

	single_answer: assert property (@(posedge clk) disable iff (!arst_n)
		instr_valid |-> in_flight && !answered)
		else $error("instr_valid while the core was not waiting for an instruction");

endmodule

bind cpu16_core cpu16_core_assertions cpu16_core_assertions_inst (
	.clk          (clk),
	.arst_n       (arst_n),
	.fetch_req    (fetch_req),
	.instr_valid  (instr_valid),
	.retire_valid (retire_valid)
);

/* hw/cpu16_core.sv */
module cpu16_core (
	input  logic                clk,
	input  logic                arst_n,
	output logic                fetch_req,
	output cpu16_pkg::word_t    fetch_addr,
	input  logic                instr_valid,
	input  cpu16_pkg::word_t    instr,
	output logic                retire_valid,
	output cpu16_pkg::retire_t  retire
);
	import cpu16_pkg::*;

	decode_t dec;
	word_t   rs_value;
	word_t   rt_value;
	word_t   alu_op2;
	word_t   alu_res;
	logic    alu_flag;
	logic    t_value;
	logic    reg_we;
	logic    t_we;
	logic    pc_step;
	logic    branch_taken;
	logic    pc_jump;

	assign alu_op2 = dec.op2_imm ? dec.imm : rt_value;  // Operand two select
	assign pc_jump = (dec.pc_act == PC_JUMP);

	control_fsm control_fsm_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.rs_value     (rs_value),
		.t_value      (t_value),
		.alu_res      (alu_res),
		.alu_flag     (alu_flag),
		.pc           (fetch_addr),
		.fetch_req    (fetch_req),
		.dec          (dec),
		.reg_we       (reg_we),
		.t_we         (t_we),
		.pc_step      (pc_step),
		.branch_taken (branch_taken),
		.retire_valid (retire_valid),
		.retire       (retire)
	);

	// Writeback data comes straight from the retire record
	reg_file reg_file_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.rs       (dec.rs),
		.rt       (dec.rt),
		.rs_value (rs_value),
		.rt_value (rt_value),
		.we       (reg_we),
		.rd       (retire.rd),
		.wd       (retire.rd_value),
		.t_we     (t_we),
		.t_wd     (retire.t_value),
		.t_value  (t_value)
	);

	alu alu_inst (
		.op   (dec.alu_op),
		.op1  (rs_value),
		.op2  (alu_op2),
		.res  (alu_res),
		.flag (alu_flag)
	);

	pc_unit pc_unit_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.step         (pc_step),
		.branch_taken (branch_taken),
		.jump         (pc_jump),
		.offset       (dec.imm),
		.target       (dec.imm),   // JR target is carried in imm
		.pc           (fetch_addr)
	);

endmodule

/* hw/control_fsm.sv */
module control_fsm (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                instr_valid,
	input  cpu16_pkg::word_t    instr,
	input  cpu16_pkg::word_t    rs_value,
	input  logic                t_value,
	input  cpu16_pkg::word_t    alu_res,
	input  logic                alu_flag,
	input  cpu16_pkg::word_t    pc,
	output logic                fetch_req,
	output cpu16_pkg::decode_t  dec,
	output logic                reg_we,
	output logic                t_we,
	output logic                pc_step,
	output logic                branch_taken,
	output logic                retire_valid,
	output cpu16_pkg::retire_t  retire
);
	import cpu16_pkg::*;

	cpu_state_t state;
	cpu_state_t state_next;
	word_t      instr_q;     // Instruction in flight
	word_t      res_q;       // ALU result from EXECUTE
	logic       flag_q;
	logic       taken_q;

	////////////////////////////////////////////////////////////
	// Sequencing
	////////////////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			RESET_WAIT: state_next = FETCH;
			FETCH:      state_next = WAIT_INSTR;
			WAIT_INSTR: if (instr_valid) state_next = EXECUTE;
			EXECUTE:    state_next = WRITEBACK;
			WRITEBACK:  state_next = FETCH;
			default:    state_next = RESET_WAIT;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= RESET_WAIT;
			taken_q <= 1'b0;
		end else begin
			state <= state_next;
			if (state == EXECUTE) begin
				taken_q <= (dec.pc_act == PC_BRANCH) ||
					((dec.pc_act == PC_COND) && alu_flag);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == WAIT_INSTR && instr_valid) begin
			instr_q <= instr;              // Late pulses are dropped
		end
		if (state == EXECUTE) begin
			res_q  <= alu_res;
			flag_q <= alu_flag;
		end
	end

	////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////

	always_comb begin
		dec         = '0;
		dec.alu_op  = ALU_PASS;
		dec.rs      = instr_q[10:8];     // rx
		dec.rt      = instr_q[7:5];      // ry
		dec.rd      = instr_q[10:8];
		dec.pc_act  = PC_INC;
		case (instr_q[15:11])
			OP_ADDIU: begin
				dec.alu_op  = ALU_ADD;
				dec.op2_imm = 1'b1;
				dec.imm     = {{8{instr_q[7]}}, instr_q[7:0]};
				dec.reg_we  = 1'b1;
			end
			OP_ADDIU3: begin
				dec.alu_op  = ALU_ADD;
				dec.op2_imm = 1'b1;
				dec.imm     = {{12{instr_q[3]}}, instr_q[3:0]};
				dec.rd      = instr_q[7:5];  // ry = rx + imm
				dec.reg_we  = 1'b1;
			end
			OP_LI: begin
				dec.op2_imm = 1'b1;
				dec.imm     = {8'b0, instr_q[7:0]};  // Zero extended
				dec.reg_we  = 1'b1;
			end
			OP_MOVE: begin
				if (instr_q[4:0] == 5'b00000) begin
					dec.reg_we = 1'b1;           // rx = ry through op2
				end
			end
			OP_SHIFT: begin
				dec.rs      = instr_q[7:5];      // Shift source is ry
				dec.op2_imm = 1'b1;
				dec.imm     = {13'b0, instr_q[4:2]};
				dec.reg_we  = (instr_q[1:0] != 2'b01);
				case (instr_q[1:0])
					2'b00:   dec.alu_op = ALU_SLL;
					2'b11:   dec.alu_op = ALU_SRA;
					2'b10:   dec.alu_op = ALU_SRL;
					default: dec.alu_op = ALU_PASS;
				endcase
			end
			OP_RRR: begin
				dec.rd     = instr_q[4:2];   // rz
				dec.reg_we = instr_q[0];     // 01 ADDU, 11 SUBU
				dec.alu_op = instr_q[1] ? ALU_SUB : ALU_ADD;
			end
			OP_RR: begin
				if (instr_q[7:0] == 8'b00000000) begin
					dec.pc_act = PC_JUMP;       // JR
					dec.imm    = rs_value;
				end else if (instr_q[4:0] == 5'b01100) begin
					dec.alu_op = ALU_AND;
					dec.reg_we = 1'b1;
				end else if (instr_q[4:0] == 5'b01101) begin
					dec.alu_op = ALU_OR;
					dec.reg_we = 1'b1;
				end else if (instr_q[4:0] == 5'b01010) begin
					dec.alu_op = ALU_NEQ;       // CMP
					dec.t_we   = 1'b1;
				end
			end
			OP_B: begin
				dec.pc_act = PC_BRANCH;
				dec.imm    = {{5{instr_q[10]}}, instr_q[10:0]};
			end
			OP_BEQZ, OP_BNEZ: begin
				dec.alu_op = instr_q[11] ? ALU_NEZ : ALU_EQZ;
				dec.pc_act = PC_COND;
				dec.imm    = {{8{instr_q[7]}}, instr_q[7:0]};
			end
			OP_BTEQZ_GROUP: begin
				if (instr_q[10:8] == 3'b000) begin
					// T is resolved here rather than in the ALU
					dec.pc_act = t_value ? PC_INC : PC_BRANCH;
					dec.imm    = {{8{instr_q[7]}}, instr_q[7:0]};
				end
			end
			OP_NOP: begin
				dec.alu_op = ALU_PASS;
			end
			default: begin
				dec.alu_op = ALU_PASS;       // Unsupported, retires as NOP
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// Strobes and retire
	////////////////////////////////////////////////////////////

	assign fetch_req    = (state == FETCH);
	assign retire_valid = (state == WRITEBACK);
	assign pc_step      = retire_valid;
	assign reg_we       = retire_valid && dec.reg_we;
	assign t_we         = retire_valid && dec.t_we;
	assign branch_taken = taken_q;

	always_comb begin
		retire.pc       = pc;
		retire.reg_we   = dec.reg_we;
		retire.rd       = dec.rd;
		retire.rd_value = res_q;
		retire.t_we     = dec.t_we;
		retire.t_value  = dec.t_we ? flag_q : t_value;  // T after this instruction
	end

endmodule

/* hw/pc_unit.sv */
module pc_unit (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             step,
	input  logic             branch_taken,
	input  logic             jump,
	input  cpu16_pkg::word_t offset,
	input  cpu16_pkg::word_t target,
	output cpu16_pkg::word_t pc
);
	import cpu16_pkg::*;

	word_t pc_inc;
	word_t pc_next;

	assign pc_inc = pc + word_t'(1);

	always_comb begin
		if (jump) begin
			pc_next = target;                // JR
		end else if (branch_taken) begin
			pc_next = pc_inc + offset;       // Relative to the next instruction
		end else begin
			pc_next = pc_inc;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
		end else if (step) begin
			pc <= pc_next;
		end
	end

endmodule

/* hw/reg_file.sv */
module reg_file (
	input  logic                clk,
	input  logic                arst_n,
	input  cpu16_pkg::reg_idx_t rs,
	input  cpu16_pkg::reg_idx_t rt,
	output cpu16_pkg::word_t    rs_value,
	output cpu16_pkg::word_t    rt_value,
	input  logic                we,
	input  cpu16_pkg::reg_idx_t rd,
	input  cpu16_pkg::word_t    wd,
	input  logic                t_we,
	input  logic                t_wd,
	output logic                t_value
);
	import cpu16_pkg::*;

	word_t regs [REG_COUNT];

	// Asynchronous reads
	assign rs_value = regs[rs];
	assign rt_value = regs[rt];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[rd] <= wd;
		end
	end

	// T register, written only by CMP
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			t_value <= 1'b0;
		end else if (t_we) begin
			t_value <= t_wd;
		end
	end

endmodule

/* hw/alu.sv */
module alu (
	input  cpu16_pkg::alu_op_t op,
	input  cpu16_pkg::word_t   op1,
	input  cpu16_pkg::word_t   op2,
	output cpu16_pkg::word_t   res,
	output logic               flag
);
	import cpu16_pkg::*;

	logic [3:0] sh_amt;
	logic [WORD_W:0] sum;      // Carry in the top bit
	logic [WORD_W:0] diff;     // Borrow in the top bit

	// A shift field of zero stands for eight
	assign sh_amt = (op2[3:0] == 4'd0) ? 4'd8 : op2[3:0];

	assign sum  = {1'b0, op1} + {1'b0, op2};
	assign diff = {1'b0, op1} - {1'b0, op2};

	////////////////////////////////////////////////////////////
	// Result and flag
	////////////////////////////////////////////////////////////

	always_comb begin
		res  = '0;
		flag = 1'b0;
		case (op)
			ALU_ADD: begin
				res  = sum[WORD_W-1:0];
				flag = sum[WORD_W];             // Carry out
			end
			ALU_SUB: begin
				res  = diff[WORD_W-1:0];
				flag = diff[WORD_W];            // Borrow out
			end
			ALU_AND: begin
				res = op1 & op2;
			end
			ALU_OR: begin
				res = op1 | op2;
			end
			ALU_SLL: begin
				res = op1 << sh_amt;
			end
			ALU_SRA: begin
				res = word_t'($signed(op1) >>> sh_amt);  // Keeps the sign
			end
			ALU_SRL: begin
				res = op1 >> sh_amt;
			end
			ALU_PASS: begin
				res = op2;                      // LI and MOVE
			end
			ALU_EQZ: begin
				flag = (op1 == '0);             // BEQZ
			end
			ALU_NEZ: begin
				flag = (op1 != '0);             // BNEZ
			end
			ALU_NEQ: begin
				flag = (op1 != op2);            // CMP writes this to T
			end
			default: begin
				res  = '0;
				flag = 1'b0;
			end
		endcase
	end

endmodule

/* hw/cpu16_pkg.sv */
package cpu16_pkg;

	////////////////////////////////////////////////////////////
	// Widths and basic types
	////////////////////////////////////////////////////////////

	localparam int WORD_W    = 16;
	localparam int REG_COUNT = 8;                   // General registers r0..r7
	localparam int REG_IDX_W = $clog2(REG_COUNT);

	typedef logic [WORD_W-1:0]    word_t;            // Data or instruction word
	typedef logic [REG_IDX_W-1:0] reg_idx_t;         // General register index
	typedef logic [4:0]           opcode_t;          // Major opcode, bits 15..11

	////////////////////////////////////////////////////////////
	// Major opcodes
	////////////////////////////////////////////////////////////

	localparam opcode_t OP_ADDIU       = 5'b01001;
	localparam opcode_t OP_ADDIU3      = 5'b01000;
	localparam opcode_t OP_B           = 5'b00010;
	localparam opcode_t OP_BEQZ        = 5'b00100;
	localparam opcode_t OP_BNEZ        = 5'b00101;
	localparam opcode_t OP_LI          = 5'b01101;
	localparam opcode_t OP_SHIFT       = 5'b00110; // SLL, SRA, SRL by bits 1..0
	localparam opcode_t OP_BTEQZ_GROUP = 5'b01100; // BTEQZ when bits 10..8 are zero
	localparam opcode_t OP_RRR         = 5'b11100; // ADDU, SUBU
	localparam opcode_t OP_RR          = 5'b11101; // AND, OR, CMP, JR
	localparam opcode_t OP_MOVE        = 5'b01111;
	localparam opcode_t OP_NOP         = 5'b00001;

	////////////////////////////////////////////////////////////
	// Enums
	////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLL,
		ALU_SRA,
		ALU_SRL,
		ALU_PASS,    // Passes op2
		ALU_EQZ,     // Flag only
		ALU_NEZ,     // Flag only
		ALU_NEQ      // Flag only
	} alu_op_t;

	typedef enum logic [2:0] {
		RESET_WAIT,
		FETCH,
		WAIT_INSTR,
		EXECUTE,
		WRITEBACK
	} cpu_state_t;

	typedef enum logic [1:0] {
		PC_INC,      // pc + 1
		PC_COND,     // Branch when ALU flag set
		PC_BRANCH,   // Always branch
		PC_JUMP      // Load target
	} pc_act_t;

	////////////////////////////////////////////////////////////
	// Bundles
	////////////////////////////////////////////////////////////

	typedef struct packed {
		alu_op_t  alu_op;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		logic     reg_we;
		logic     t_we;
		logic     op2_imm;   // Operand two from imm, else rt
		word_t    imm;       // Extended immediate, offset or jump target
		pc_act_t  pc_act;
	} decode_t;

	typedef struct packed {
		word_t    pc;
		logic     reg_we;
		reg_idx_t rd;
		word_t    rd_value;
		logic     t_we;
		logic     t_value;
	} retire_t;

endpackage
